// ==== design/lsu_cmd_decode.sv ====
`timescale 1ns/100ps

module lsu_cmd_decode
    import lsu_pkg::*;
(
    input  logic        exu_req_i,              // Only for the X-check below
    input  lsu_cmd_e    exu_cmd_i,              // Command from execute stage
    lsu_cmd_if.src      cmd_if,                 // Decoded flags
    output mem_cmd_e    dmem_cmd_o,             // Read or write
    output mem_width_e  dmem_width_o            // Access width
);

    logic wdth_byte;
    logic wdth_hword;
    logic wdth_word;

    // ------------------------------
    // Command class and width
    // ------------------------------
    assign cmd_if.is_load  = cmd_is_load(exu_cmd_i);
    assign cmd_if.is_store = cmd_is_store(exu_cmd_i);

    assign wdth_byte  = exu_cmd_i inside {lsu_cmd_lb, lsu_cmd_lbu, lsu_cmd_sb};
    assign wdth_hword = exu_cmd_i inside {lsu_cmd_lh, lsu_cmd_lhu, lsu_cmd_sh};
    assign wdth_word  = exu_cmd_i inside {lsu_cmd_lw, lsu_cmd_sw};

    assign cmd_if.wdth_byte  = wdth_byte;
    assign cmd_if.wdth_hword = wdth_hword;
    assign cmd_if.wdth_word  = wdth_word;

    // ------------------------------
    // Memory command fields
    // ------------------------------
    assign dmem_cmd_o   = cmd_if.is_store ? mem_cmd_wr : mem_cmd_rd;
    assign dmem_width_o = wdth_byte  ? mem_width_byte
                        : wdth_hword ? mem_width_hword
                                     : mem_width_word;  // Word also for none

    // Execute stage must present a defined command with its request
    always_comb begin
        if (exu_req_i) begin
            assert (!$isunknown(exu_cmd_i))
                else $error("LSU: unknown command while request pending");
        end
    end

endmodule

// ==== design/lsu_cmd_if.sv ====
`timescale 1ns/100ps

// Decoded form of the execute-stage command, same cycle as the command
interface lsu_cmd_if;

    logic is_load;                              // Any of lb/lbu/lh/lhu/lw
    logic is_store;                             // Any of sb/sh/sw
    logic wdth_byte;
    logic wdth_hword;
    logic wdth_word;

    // Decoder side
    modport src (
        output is_load, is_store,
        output wdth_byte, wdth_hword, wdth_word
    );

    // Request control and exception side
    modport dst (
        input  is_load, is_store,
        input  wdth_byte, wdth_hword, wdth_word
    );

endinterface

// ==== design/lsu_exc_unit.sv ====
`timescale 1ns/100ps

module lsu_exc_unit
    import lsu_pkg::*;
#(
    parameter int DMEM_AWIDTH = 32
) (
    input  logic                   exu_req_i,
    input  logic [DMEM_AWIDTH-1:0] exu_addr_i,  // Only the low bits decide alignment
    lsu_cmd_if.dst                 cmd_if,
    input  logic                   resp_err,    // Error response of the access in flight
    input  lsu_cmd_e               cmd_ff,
    output logic                   misalign_exc,
    output logic                   lsu_exc_o,
    output exc_code_e              lsu_exc_code_o
);

    logic mslgn;
    logic mslgn_l;                              // Load misalign
    logic mslgn_s;                              // Store misalign
    logic ff_load;
    logic ff_store;

    // ------------------------------
    // Misalignment
    // ------------------------------
    assign mslgn = exu_req_i & ((cmd_if.wdth_hword & exu_addr_i[0])
                              | (cmd_if.wdth_word  & |exu_addr_i[1:0]));  // Bytes never fault

    assign mslgn_l      = mslgn & cmd_if.is_load;
    assign mslgn_s      = mslgn & cmd_if.is_store;
    assign misalign_exc = mslgn_l | mslgn_s;

    // Class of the registered command, for access faults
    assign ff_load  = cmd_is_load(cmd_ff);
    assign ff_store = cmd_is_store(cmd_ff);

    // ------------------------------
    // Code selection, error first
    // ------------------------------
    always_comb begin
        lsu_exc_code_o = exc_code_instr_misalign;   // Default cause
        if (resp_err) begin
            if (ff_load) begin
                lsu_exc_code_o = exc_code_ld_access_fault;
            end else if (ff_store) begin
                lsu_exc_code_o = exc_code_st_access_fault;
            end
        end else if (mslgn_l) begin
            lsu_exc_code_o = exc_code_ld_addr_misalign;
        end else if (mslgn_s) begin
            lsu_exc_code_o = exc_code_st_addr_misalign;
        end
    end

    assign lsu_exc_o = resp_err | misalign_exc;

    // Error can only come for an aligned access, so sources never overlap
    always_comb begin
        assert ($onehot0({resp_err, mslgn_l, mslgn_s}))
            else $error("LSU: more than one exception source");
        if (lsu_exc_o) begin
            assert (exu_req_i)
                else $error("LSU: exception without pending request");
        end
        if (exu_req_i) begin
            assert (!$isunknown(exu_addr_i))
                else $error("LSU: unknown address while request pending");
        end
    end

endmodule

// ==== design/lsu_load_ext.sv ====
`timescale 1ns/100ps

module lsu_load_ext
    import lsu_pkg::*;
(
    input  lsu_cmd_e             cmd_ff,        // Registered command
    input  logic [lsu_xlen-1:0]  dmem_rdata_i,  // Raw word from memory
    output logic [lsu_xlen-1:0]  lsu_ldata_o    // Extended load result
);

    // ------------------------------
    // Sign or zero extension
    // ------------------------------
    always_comb begin
        case (cmd_ff)
            lsu_cmd_lh: begin
                lsu_ldata_o = {{(lsu_xlen-16){dmem_rdata_i[15]}}, dmem_rdata_i[15:0]};
            end
            lsu_cmd_lhu: begin
                lsu_ldata_o = {{(lsu_xlen-16){1'b0}}, dmem_rdata_i[15:0]};
            end
            lsu_cmd_lb: begin
                lsu_ldata_o = {{(lsu_xlen-8){dmem_rdata_i[7]}}, dmem_rdata_i[7:0]};
            end
            lsu_cmd_lbu: begin
                lsu_ldata_o = {{(lsu_xlen-8){1'b0}}, dmem_rdata_i[7:0]};
            end
            default: begin
                lsu_ldata_o = dmem_rdata_i;     // lw and non-load commands
            end
        endcase
    end

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int lsu_xlen = 32;               // Data word width, fixed by load extension

    // ------------------------------
    // Command and memory encodings
    // ------------------------------
    typedef enum logic [3:0] {
        lsu_cmd_none = 4'd0,
        lsu_cmd_lb   = 4'd1,
        lsu_cmd_lh   = 4'd2,
        lsu_cmd_lw   = 4'd3,
        lsu_cmd_lbu  = 4'd4,
        lsu_cmd_lhu  = 4'd5,
        lsu_cmd_sb   = 4'd6,
        lsu_cmd_sh   = 4'd7,
        lsu_cmd_sw   = 4'd8
    } lsu_cmd_e;

    typedef enum logic [1:0] {
        mem_resp_notrdy = 2'd0,                 // Access still in progress
        mem_resp_rdy_ok = 2'd1,
        mem_resp_rdy_er = 2'd2                  // Bus error
    } mem_resp_e;

    typedef enum logic [1:0] {
        mem_width_byte  = 2'd0,
        mem_width_hword = 2'd1,
        mem_width_word  = 2'd2
    } mem_width_e;

    typedef enum logic {
        mem_cmd_rd = 1'b0,
        mem_cmd_wr = 1'b1
    } mem_cmd_e;

    // Cause values as in mcause
    typedef enum logic [3:0] {
        exc_code_instr_misalign   = 4'd0,
        exc_code_ld_addr_misalign = 4'd4,
        exc_code_ld_access_fault  = 4'd5,
        exc_code_st_addr_misalign = 4'd6,
        exc_code_st_access_fault  = 4'd7
    } exc_code_e;

    // Command class helpers, used on live and registered command
    function automatic logic cmd_is_load(lsu_cmd_e cmd);
        return cmd inside {lsu_cmd_lb, lsu_cmd_lbu, lsu_cmd_lh, lsu_cmd_lhu, lsu_cmd_lw};
    endfunction

    function automatic logic cmd_is_store(lsu_cmd_e cmd);
        return cmd inside {lsu_cmd_sb, lsu_cmd_sh, lsu_cmd_sw};
    endfunction

endpackage

// ==== design/lsu_req_ctrl.sv ====
`timescale 1ns/100ps

module lsu_req_ctrl
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exu_req_i,              // Level, held until ready or exception
    input  lsu_cmd_e    exu_cmd_i,              // Command from execute stage
    lsu_cmd_if.dst      cmd_if,                 // Decoded live command
    input  logic        misalign_exc,           // Blocks the memory request
    input  logic        dmem_req_ack_i,
    input  mem_resp_e   dmem_resp_i,
    output logic        dmem_req_o,
    output logic        lsu_rdy_o,              // Access done, ok or error
    output logic        resp_err,               // Error response this cycle
    output lsu_cmd_e    cmd_ff                  // Command of the access in flight
);

    localparam logic st_idle = 1'b0;
    localparam logic st_busy = 1'b1;

    logic     state_ff;
    logic     state_nxt;
    logic     fsm_idle;
    logic     mem_op;                           // Live command touches memory
    logic     resp_ok;
    logic     resp_rcvd;
    logic     req_vd;                           // Request accepted this edge

    // ------------------------------
    // Response and request decode
    // ------------------------------
    assign resp_ok   = (dmem_resp_i == mem_resp_rdy_ok);
    assign resp_err  = (dmem_resp_i == mem_resp_rdy_er);
    assign resp_rcvd = resp_ok | resp_err;     // Anything but not-ready

    assign mem_op = cmd_if.is_load | cmd_if.is_store;
    assign req_vd = exu_req_i & mem_op & dmem_req_ack_i & ~misalign_exc;

    // Command register, loaded at acceptance only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ff <= lsu_cmd_none;
        end else if (fsm_idle && req_vd) begin
            cmd_ff <= exu_cmd_i;
        end
    end

    // ------------------------------
    // Idle/busy FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff <= st_idle;
        end else begin
            state_ff <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state_ff;
        case (state_ff)
            st_idle: if (req_vd)    state_nxt = st_busy;  // One access in flight
            st_busy: if (resp_rcvd) state_nxt = st_idle;
            default:                state_nxt = st_idle;
        endcase
    end

    assign fsm_idle = (state_ff == st_idle);

    assign dmem_req_o = exu_req_i & mem_op & ~misalign_exc & fsm_idle;  // Held under back-pressure
    assign lsu_rdy_o  = resp_rcvd;

    // Memory must stay silent until an access was accepted
    a_no_resp_idle : assert property (@(posedge clk) disable iff (!rst_n)
        fsm_idle |-> !resp_rcvd)
        else $error("LSU: memory response while idle");

    a_ctrl_known : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({exu_req_i, state_ff, dmem_resp_i})
        && (!dmem_req_o || !$isunknown(dmem_req_ack_i)))
        else $error("LSU: unknown control value");

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int DMEM_AWIDTH = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Execute stage side
    input  logic                   exu_req_i,
    input  lsu_cmd_e               exu_cmd_i,
    input  logic [lsu_xlen-1:0]    exu_addr_i,
    input  logic [lsu_xlen-1:0]    exu_sdata_i,
    output logic                   lsu_rdy_o,
    output logic [lsu_xlen-1:0]    lsu_ldata_o,
    output logic                   lsu_exc_o,
    output exc_code_e              lsu_exc_code_o,

    // Data memory side
    output logic                   dmem_req_o,
    output mem_cmd_e               dmem_cmd_o,
    output mem_width_e             dmem_width_o,
    output logic [DMEM_AWIDTH-1:0] dmem_addr_o,
    output logic [lsu_xlen-1:0]    dmem_wdata_o,
    input  logic                   dmem_req_ack_i,
    input  logic [lsu_xlen-1:0]    dmem_rdata_i,
    input  mem_resp_e              dmem_resp_i
);

    logic     misalign_exc;
    logic     resp_err;
    lsu_cmd_e cmd_ff;

    lsu_cmd_if cmd_if ();                       // Live decoded command

    assign dmem_addr_o  = exu_addr_i[DMEM_AWIDTH-1:0];
    assign dmem_wdata_o = exu_sdata_i;

    lsu_cmd_decode u_cmd_decode (
        .exu_req_i    (exu_req_i),
        .exu_cmd_i    (exu_cmd_i),
        .cmd_if       (cmd_if.src),
        .dmem_cmd_o   (dmem_cmd_o),
        .dmem_width_o (dmem_width_o)
    );

    lsu_req_ctrl u_req_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .exu_req_i      (exu_req_i),
        .exu_cmd_i      (exu_cmd_i),
        .cmd_if         (cmd_if.dst),
        .misalign_exc   (misalign_exc),
        .dmem_req_ack_i (dmem_req_ack_i),
        .dmem_resp_i    (dmem_resp_i),
        .dmem_req_o     (dmem_req_o),
        .lsu_rdy_o      (lsu_rdy_o),
        .resp_err       (resp_err),
        .cmd_ff         (cmd_ff)
    );

    lsu_exc_unit #(
        .DMEM_AWIDTH (DMEM_AWIDTH)
    ) u_exc_unit (
        .exu_req_i      (exu_req_i),
        .exu_addr_i     (exu_addr_i[DMEM_AWIDTH-1:0]),
        .cmd_if         (cmd_if.dst),
        .resp_err       (resp_err),
        .cmd_ff         (cmd_ff),
        .misalign_exc   (misalign_exc),
        .lsu_exc_o      (lsu_exc_o),
        .lsu_exc_code_o (lsu_exc_code_o)
    );

    lsu_load_ext u_load_ext (
        .cmd_ff       (cmd_ff),
        .dmem_rdata_i (dmem_rdata_i),
        .lsu_ldata_o  (lsu_ldata_o)
    );

endmodule

// ==== filelist.f ====
design/lsu_pkg.sv
design/lsu_cmd_if.sv
design/lsu_cmd_decode.sv
design/lsu_req_ctrl.sv
design/lsu_exc_unit.sv
design/lsu_load_ext.sv
design/lsu_top.sv
testbench/tb_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_lsu -o Vtb_lsu

./obj_dir/Vtb_lsu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/100ps

module tb_lsu
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_TESTS    = 18;
    localparam int RDY_LIMIT  = 10;             // Cycles allowed for the ready pulse

    typedef struct packed {
        lsu_cmd_e    cmd;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [31:0] rdata;                     // Word returned by the memory model
        mem_resp_e   resp;
        int          ack_delay;                 // Cycles of back-pressure before ack
        logic        mis;                       // Faults in the request cycle
        logic        exp_exc;
        exc_code_e   exp_code;
        logic [31:0] exp_ldata;
    } test_entry_t;

    logic        clk;
    logic        rst_n;
    logic        exu_req_i;
    lsu_cmd_e    exu_cmd_i;
    logic [31:0] exu_addr_i;
    logic [31:0] exu_sdata_i;
    logic        lsu_rdy_o;
    logic [31:0] lsu_ldata_o;
    logic        lsu_exc_o;
    exc_code_e   lsu_exc_code_o;
    logic        dmem_req_o;
    mem_cmd_e    dmem_cmd_o;
    mem_width_e  dmem_width_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        dmem_req_ack_i;
    logic [31:0] dmem_rdata_i;
    mem_resp_e   dmem_resp_i;

    test_entry_t tests [N_TESTS];
    int          n_loaded;
    int          test_errs;                     // Errors of the running test
    int          fail_total;
    integer      seed;

    lsu_top #(
        .DMEM_AWIDTH (32)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .exu_req_i      (exu_req_i),
        .exu_cmd_i      (exu_cmd_i),
        .exu_addr_i     (exu_addr_i),
        .exu_sdata_i    (exu_sdata_i),
        .lsu_rdy_o      (lsu_rdy_o),
        .lsu_ldata_o    (lsu_ldata_o),
        .lsu_exc_o      (lsu_exc_o),
        .lsu_exc_code_o (lsu_exc_code_o),
        .dmem_req_o     (dmem_req_o),
        .dmem_cmd_o     (dmem_cmd_o),
        .dmem_width_o   (dmem_width_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_req_ack_i (dmem_req_ack_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .dmem_resp_i    (dmem_resp_i)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;          // 8 ns period

    // ------------------------------
    // Reference rules
    // ------------------------------
    function automatic logic [31:0] extend_ref(lsu_cmd_e cmd, logic [31:0] word);
        case (cmd)
            lsu_cmd_lb:  return {{24{word[7]}}, word[7:0]};
            lsu_cmd_lbu: return {24'h0, word[7:0]};
            lsu_cmd_lh:  return {{16{word[15]}}, word[15:0]};
            lsu_cmd_lhu: return {16'h0, word[15:0]};
            default:     return word;           // Full word
        endcase
    endfunction

    function automatic mem_width_e width_ref(lsu_cmd_e cmd);
        case (cmd)
            lsu_cmd_lb, lsu_cmd_lbu, lsu_cmd_sb: return mem_width_byte;
            lsu_cmd_lh, lsu_cmd_lhu, lsu_cmd_sh: return mem_width_hword;
            default:                             return mem_width_word;
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic add_test(input lsu_cmd_e cmd, input logic [31:0] addr,
                            input logic [31:0] sdata, input logic [31:0] rdata,
                            input mem_resp_e resp, input int ack_delay,
                            input logic exp_exc, input exc_code_e exp_code);
        test_entry_t t;
        t.cmd       = cmd;
        t.addr      = addr;
        t.sdata     = sdata;
        t.rdata     = rdata;
        t.resp      = resp;
        t.ack_delay = ack_delay;
        t.mis       = exp_exc && (resp == mem_resp_notrdy);  // No memory access at all
        t.exp_exc   = exp_exc;
        t.exp_code  = exp_code;
        t.exp_ldata = extend_ref(cmd, rdata);
        tests[n_loaded] = t;
        n_loaded++;
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic load_table();
        add_test(lsu_cmd_lw,  32'h100, 32'h0, 32'h89AB_CDEF, mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_lb,  32'h101, 32'h0, $random(seed), mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_lbu, 32'h103, 32'h0, $random(seed), mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_lh,  32'h102, 32'h0, $random(seed), mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_lhu, 32'h106, 32'h0, $random(seed), mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_lb,  32'h108, 32'h0, 32'h1234_5680, mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);  // Negative byte
        add_test(lsu_cmd_lh,  32'h10A, 32'h0, 32'h0000_8001, mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);  // Negative half
        add_test(lsu_cmd_sb,  32'h203, 32'h55, 32'h0, mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_sh,  32'h202, 32'hBEEF, 32'h0, mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_sw,  32'h204, 32'hCAFE_F00D, 32'h0, mem_resp_rdy_ok, 0, 1'b0,
                 exc_code_instr_misalign);
        add_test(lsu_cmd_lh,  32'h101, 32'h0, 32'h0, mem_resp_notrdy, 0, 1'b1,
                 exc_code_ld_addr_misalign);
        add_test(lsu_cmd_lw,  32'h102, 32'h0, 32'h0, mem_resp_notrdy, 0, 1'b1,
                 exc_code_ld_addr_misalign);
        add_test(lsu_cmd_sh,  32'h303, 32'h1, 32'h0, mem_resp_notrdy, 0, 1'b1,
                 exc_code_st_addr_misalign);
        add_test(lsu_cmd_sw,  32'h301, 32'h2, 32'h0, mem_resp_notrdy, 0, 1'b1,
                 exc_code_st_addr_misalign);
        add_test(lsu_cmd_lw,  32'h400, 32'h0, 32'h0, mem_resp_rdy_er, 0, 1'b1,
                 exc_code_ld_access_fault);
        add_test(lsu_cmd_sb,  32'h401, 32'h7, 32'h0, mem_resp_rdy_er, 0, 1'b1,
                 exc_code_st_access_fault);
        add_test(lsu_cmd_lw,  32'h500, 32'h0, 32'h0F0F_A5A5, mem_resp_rdy_ok, 3, 1'b0,
                 exc_code_instr_misalign);  // Back-pressure
        add_test(lsu_cmd_sw,  32'h504, 32'h1357_9BDF, 32'h0, mem_resp_rdy_ok, 2, 1'b0,
                 exc_code_instr_misalign);
    endtask

    // ------------------------------
    // One access with memory model
    // ------------------------------
    task automatic run_test(input int idx);
        test_entry_t t;
        int          cycles;
        logic        is_store;
        t         = tests[idx];
        test_errs = 0;
        is_store  = (t.cmd == lsu_cmd_sb) || (t.cmd == lsu_cmd_sh) || (t.cmd == lsu_cmd_sw);
        @(negedge clk);
        exu_req_i      = 1'b1;
        exu_cmd_i      = t.cmd;
        exu_addr_i     = t.addr;
        exu_sdata_i    = t.sdata;
        dmem_req_ack_i = (t.ack_delay == 0) && !t.mis;      // Ack in the request cycle
        #2;
        if (t.mis) begin
            compare_field("lsu_exc_o", 32'(lsu_exc_o), 32'(1'b1));
            compare_field("lsu_exc_code_o", 32'(lsu_exc_code_o), 32'(t.exp_code));
            compare_field("dmem_req_o", 32'(dmem_req_o), 32'(1'b0));
        end else begin
            compare_field("dmem_req_o", 32'(dmem_req_o), 32'(1'b1));
            compare_field("lsu_exc_o", 32'(lsu_exc_o), 32'(1'b0));
            compare_field("lsu_rdy_o", 32'(lsu_rdy_o), 32'(1'b0));
            compare_field("dmem_cmd_o", 32'(dmem_cmd_o), 32'(is_store));
            compare_field("dmem_width_o", 32'(dmem_width_o), 32'(width_ref(t.cmd)));
            compare_field("dmem_addr_o", dmem_addr_o, t.addr);
            compare_field("dmem_wdata_o", dmem_wdata_o, t.sdata);
            cycles = 0;
            while (cycles < t.ack_delay) begin  // Request must hold under back-pressure
                @(negedge clk);
                cycles++;
                dmem_req_ack_i = (cycles == t.ack_delay);
                #2;
                compare_field("dmem_req_o", 32'(dmem_req_o), 32'(1'b1));
                compare_field("lsu_rdy_o", 32'(lsu_rdy_o), 32'(1'b0));
            end
            // Response one cycle after acceptance
            @(negedge clk);
            dmem_req_ack_i = 1'b0;
            dmem_resp_i    = t.resp;
            dmem_rdata_i   = t.rdata;
            #2;
            cycles = 0;
            while (!lsu_rdy_o && cycles < RDY_LIMIT) begin
                @(negedge clk);
                #2;
                cycles++;
            end
            if (!lsu_rdy_o) begin
                $display("Test %0d: no ready pulse within %0d cycles", idx, RDY_LIMIT);
                test_errs++;
            end else begin
                compare_field("lsu_exc_o", 32'(lsu_exc_o), 32'(t.exp_exc));
                compare_field("dmem_req_o", 32'(dmem_req_o), 32'(1'b0));  // Busy
                if (t.exp_exc) begin
                    compare_field("lsu_exc_code_o", 32'(lsu_exc_code_o), 32'(t.exp_code));
                end else if (!is_store) begin
                    compare_field("lsu_ldata_o", lsu_ldata_o, t.exp_ldata);
                end
            end
        end
        @(negedge clk);                         // Drop request, back to idle
        exu_req_i      = 1'b0;
        exu_cmd_i      = lsu_cmd_none;
        dmem_req_ack_i = 1'b0;
        dmem_resp_i    = mem_resp_notrdy;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        seed           = 6828;
        n_loaded       = 0;
        fail_total     = 0;
        rst_n          = 1'b0;
        exu_req_i      = 1'b0;
        exu_cmd_i      = lsu_cmd_none;
        exu_addr_i     = 32'h0;
        exu_sdata_i    = 32'h0;
        dmem_req_ack_i = 1'b0;
        dmem_rdata_i   = 32'h0;
        dmem_resp_i    = mem_resp_notrdy;
        load_table();
        repeat (5) @(posedge clk);              // 5 cycles in reset
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            run_test(i);
            if (test_errs == 0) begin
                $display("Test %0d %s: pass", i, tests[i].cmd.name());
            end else begin
                $display("Test %0d %s: FAIL (%0d errors)", i, tests[i].cmd.name(), test_errs);
                fail_total++;
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d",
                 N_TESTS, N_TESTS - fail_total, fail_total);
        if (fail_total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from table length
    initial begin
        #((N_TESTS * 20 + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("Test failures found");
        $finish;
    end

endmodule
